// ==== src/wb_bus_defines.svh ====
// Bus size macros shared by the package and the RTL
// Include wherever a width or the master count is needed
`ifndef WB_BUS_DEFINES_SVH
`define WB_BUS_DEFINES_SVH

// Number of masters sharing the RAM
`define WB_PORTS 4

// Word address width, 64 words
`define WB_ADDR_W 6

// Data width, byte selects follow from it
`define WB_DATA_W 32

`endif

// ==== src/wb_bus_pkg.sv ====
// Field types of the shared Wishbone bus
// Sized from the defines header, import where a type is used

`include "wb_bus_defines.svh"

package wb_bus_pkg;

    // Word address into the RAM
    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

    // One data word
    typedef logic [`WB_DATA_W-1:0] wb_data_t;

    // One select bit per data byte
    typedef logic [`WB_DATA_W/8-1:0] wb_sel_t;

    // One bit per master, request and grant vectors
    typedef logic [`WB_PORTS-1:0] port_mask_t;

    // Encoded master number
    typedef logic [$clog2(`WB_PORTS)-1:0] port_idx_t;

endpackage

// ==== src/priority_encoder.sv ====
// Combinational priority encoder, valid flag plus index and one-hot of winner
// LSB_HIGH_PRIORITY picks which end of the vector wins
`timescale 1ns/100ps

module priority_encoder #(
    parameter int WIDTH = 4,
    parameter bit LSB_HIGH_PRIORITY = 1'b0
) (
    input  logic [WIDTH-1:0]         input_unencoded,
    output logic                     output_valid,
    output logic [$clog2(WIDTH)-1:0] output_encoded,
    output logic [WIDTH-1:0]         output_unencoded
);

    localparam int IDX_W = $clog2(WIDTH);

    always_comb begin
        output_valid   = |input_unencoded;
        output_encoded = '0;
        if (LSB_HIGH_PRIORITY) begin
            // Scan downward so the lowest set bit is written last
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (input_unencoded[i]) begin
                    output_encoded = IDX_W'(i);
                end
            end
        end else begin
            // Scan upward, highest set bit wins
            for (int i = 0; i < WIDTH; i++) begin
                if (input_unencoded[i]) begin
                    output_encoded = IDX_W'(i);
                end
            end
        end
    end

    // One-hot of the winner, zero when nothing requests
    always_comb begin
        output_unencoded = '0;
        if (output_valid) begin
            output_unencoded[output_encoded] = 1'b1;
        end
    end

endmodule

// ==== src/arbiter.sv ====
// Registered round-robin arbiter for the shared bus
// Grant stays with a master until its request (cyc) drops
`timescale 1ns/100ps

`include "wb_bus_defines.svh"

module arbiter #(
    parameter int PORTS = `WB_PORTS,
    parameter bit ROUND_ROBIN = 1'b1 // Off gives fixed priority, port 0 highest
) (
    input  logic                  clk,
    input  logic                  rst,
    input  wb_bus_pkg::port_mask_t request,
    output wb_bus_pkg::port_mask_t grant,
    output logic                  grant_valid,
    output wb_bus_pkg::port_idx_t grant_encoded
);

    import wb_bus_pkg::*;

    port_mask_t grant_next;
    logic       grant_valid_next;
    port_idx_t  grant_encoded_next;

    // Ports still eligible this round, above the last winner
    port_mask_t mask_reg;
    port_mask_t mask_next;

    logic       req_valid;      // Any request at all
    port_idx_t  req_idx;
    port_mask_t req_onehot;

    port_mask_t masked_request;
    logic       mreq_valid;     // Any request above last winner
    port_idx_t  mreq_idx;
    port_mask_t mreq_onehot;

    assign masked_request = request & mask_reg;

    priority_encoder #(
        .WIDTH(PORTS),
        .LSB_HIGH_PRIORITY(1'b1)
    ) u_pe_raw (
        .input_unencoded (request),
        .output_valid    (req_valid),
        .output_encoded  (req_idx),
        .output_unencoded(req_onehot)
    );

    priority_encoder #(
        .WIDTH(PORTS),
        .LSB_HIGH_PRIORITY(1'b1)
    ) u_pe_masked (
        .input_unencoded (masked_request),
        .output_valid    (mreq_valid),
        .output_encoded  (mreq_idx),
        .output_unencoded(mreq_onehot)
    );

    always_comb begin
        grant_next         = '0;
        grant_valid_next   = 1'b0;
        grant_encoded_next = '0;
        mask_next          = mask_reg;

        if (|(grant & request)) begin
            // Owner still holds cyc
            grant_next         = grant;
            grant_valid_next   = grant_valid;
            grant_encoded_next = grant_encoded;
        end else if (ROUND_ROBIN && mreq_valid) begin
            grant_next         = mreq_onehot;
            grant_valid_next   = 1'b1;
            grant_encoded_next = mreq_idx;
            mask_next          = {PORTS{1'b1}} << (mreq_idx + 1); // Winner and below out
        end else if (req_valid) begin
            // Nothing above last winner, wrap to lowest requester
            grant_next         = req_onehot;
            grant_valid_next   = 1'b1;
            grant_encoded_next = req_idx;
            if (ROUND_ROBIN) begin
                mask_next = {PORTS{1'b1}} << (req_idx + 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant         <= '0;
            grant_valid   <= 1'b0;
            grant_encoded <= '0;
            mask_reg      <= '0;
        end else begin
            grant         <= grant_next;
            grant_valid   <= grant_valid_next;
            grant_encoded <= grant_encoded_next;
            mask_reg      <= mask_next;
        end
    end

endmodule

// ==== src/wb_master_mux.sv ====
// Master-side multiplexer of the shared Wishbone bus
// Granted master drives the slave, ack goes back to that master alone
`timescale 1ns/100ps

`include "wb_bus_defines.svh"

module wb_master_mux (
    input  logic                  grant_valid,
    input  wb_bus_pkg::port_idx_t grant_encoded,

    // Master side, one entry per master
    input  wb_bus_pkg::port_mask_t m_stb,
    input  wb_bus_pkg::port_mask_t m_we,
    input  wb_bus_pkg::wb_addr_t  m_adr   [`WB_PORTS],
    input  wb_bus_pkg::wb_data_t  m_dat_w [`WB_PORTS],
    input  wb_bus_pkg::wb_sel_t   m_sel   [`WB_PORTS],
    output wb_bus_pkg::port_mask_t m_ack,
    output wb_bus_pkg::wb_data_t  m_dat_r [`WB_PORTS],

    // Slave side
    output logic                  s_cyc,
    output logic                  s_stb,
    output logic                  s_we,
    output wb_bus_pkg::wb_addr_t  s_adr,
    output wb_bus_pkg::wb_data_t  s_dat_w,
    output wb_bus_pkg::wb_sel_t   s_sel,
    input  logic                  s_ack,
    input  wb_bus_pkg::wb_data_t  s_dat_r
);

    import wb_bus_pkg::*;

    // Forward path, idle bus when nobody owns it
    always_comb begin
        s_cyc   = 1'b0;
        s_stb   = 1'b0;
        s_we    = 1'b0;
        s_adr   = '0;
        s_dat_w = '0;
        s_sel   = '0;
        if (grant_valid) begin
            s_cyc   = 1'b1;                  // Held for the whole ownership
            s_stb   = m_stb[grant_encoded];
            s_we    = m_we[grant_encoded];
            s_adr   = m_adr[grant_encoded];
            s_dat_w = m_dat_w[grant_encoded];
            s_sel   = m_sel[grant_encoded];
        end
    end

    // Return path
    always_comb begin
        for (int i = 0; i < `WB_PORTS; i++) begin
            // Ack steered by the decoded grant index
            m_ack[i]   = s_ack && grant_valid && (grant_encoded == port_idx_t'(i));
            m_dat_r[i] = s_dat_r; // Broadcast, only valid with ack
        end
    end

endmodule

// ==== src/wb_ram.sv ====
// Wishbone classic RAM slave, 64 words with byte selects
// Registered ack one cycle after cyc and stb, read data comes with it
`timescale 1ns/100ps

`include "wb_bus_defines.svh"

module wb_ram (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  wb_bus_pkg::wb_addr_t adr,
    input  wb_bus_pkg::wb_data_t dat_w,
    input  wb_bus_pkg::wb_sel_t  sel,
    output logic                 ack,
    output wb_bus_pkg::wb_data_t dat_r
);

    import wb_bus_pkg::*;

    wb_data_t mem [2**`WB_ADDR_W];

    logic access; // New transfer this cycle

    // Ack low check stops a held strobe from being served twice
    assign access = cyc && stb && !ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= access; // Single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (we) begin
                for (int b = 0; b < $bits(wb_sel_t); b++) begin
                    if (sel[b]) begin
                        mem[adr][b*8 +: 8] <= dat_w[b*8 +: 8];
                    end
                end
            end else begin
                dat_r <= mem[adr]; // Lines up with ack
            end
        end
    end

endmodule

// ==== src/wb_shared_bus.sv ====
// Top of the shared Wishbone bus with four masters onto one RAM
// Each master gets its own classic slave port and its cyc doubles as bus request
`timescale 1ns/100ps

`include "wb_bus_defines.svh"

module wb_shared_bus (
    input  logic                   clk,
    input  logic                   rst,
    input  wb_bus_pkg::port_mask_t m_cyc,
    input  wb_bus_pkg::port_mask_t m_stb,
    input  wb_bus_pkg::port_mask_t m_we,
    input  wb_bus_pkg::wb_addr_t   m_adr   [`WB_PORTS],
    input  wb_bus_pkg::wb_data_t   m_dat_w [`WB_PORTS],
    input  wb_bus_pkg::wb_sel_t    m_sel   [`WB_PORTS],
    output wb_bus_pkg::port_mask_t m_ack,
    output wb_bus_pkg::wb_data_t   m_dat_r [`WB_PORTS]
);

    import wb_bus_pkg::*;

    logic       grant_valid;
    port_idx_t  grant_encoded; // Owner index for the mux

    // Slave side of the mux
    logic     s_cyc;
    logic     s_stb;
    logic     s_we;
    wb_addr_t s_adr;
    wb_data_t s_dat_w;
    wb_sel_t  s_sel;
    logic     s_ack;
    wb_data_t s_dat_r;

    arbiter #(
        .PORTS(`WB_PORTS),
        .ROUND_ROBIN(1'b1)
    ) u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .request      (m_cyc),
        .grant        (),
        .grant_valid  (grant_valid),
        .grant_encoded(grant_encoded)
    );

    wb_master_mux u_wb_master_mux (
        .grant_valid  (grant_valid),
        .grant_encoded(grant_encoded),
        .m_stb        (m_stb),
        .m_we         (m_we),
        .m_adr        (m_adr),
        .m_dat_w      (m_dat_w),
        .m_sel        (m_sel),
        .m_ack        (m_ack),
        .m_dat_r      (m_dat_r),
        .s_cyc        (s_cyc),
        .s_stb        (s_stb),
        .s_we         (s_we),
        .s_adr        (s_adr),
        .s_dat_w      (s_dat_w),
        .s_sel        (s_sel),
        .s_ack        (s_ack),
        .s_dat_r      (s_dat_r)
    );

    wb_ram u_wb_ram (
        .clk  (clk),
        .rst  (rst),
        .cyc  (s_cyc),
        .stb  (s_stb),
        .we   (s_we),
        .adr  (s_adr),
        .dat_w(s_dat_w),
        .sel  (s_sel),
        .ack  (s_ack),
        .dat_r(s_dat_r)
    );

endmodule

// ==== testbench/tb_wb_shared_bus.sv ====
// Testbench for the shared Wishbone bus with four LFSR-driven masters and a reference memory
// Checks reset quiet, read data, ack routing, latency, round-robin order and locked ownership
`timescale 1ns/100ps

`include "wb_bus_defines.svh"

module tb_wb_shared_bus;

    import wb_bus_pkg::*;

    localparam int PORTS      = `WB_PORTS;
    localparam int WORDS      = 2**`WB_ADDR_W;
    localparam int FAIR_XFERS = 12; // Per master with all four busy
    localparam int LOCK_XFERS = 6;  // Back to back under one cyc
    localparam int MIX_XFERS  = 16;
    // Upper bound of transfers by any one master over the run
    localparam int XFER_COUNT = WORDS + 1 + FAIR_XFERS + LOCK_XFERS + MIX_XFERS;
    localparam int WATCHDOG_CYCLES = PORTS * XFER_COUNT * 20;

    logic       clk = 1'b0;
    logic       rst;
    port_mask_t m_cyc;
    port_mask_t m_stb;
    port_mask_t m_we;
    wb_addr_t   m_adr   [PORTS];
    wb_data_t   m_dat_w [PORTS];
    wb_sel_t    m_sel   [PORTS];
    port_mask_t m_ack;
    wb_data_t   m_dat_r [PORTS];

    wb_data_t    ref_mem [WORDS];     // Expected RAM contents
    logic [31:0] lfsr_state [PORTS];  // One generator per master
    logic        fair_mode;           // Rotation check enabled

    // Monitor state
    logic prev_rst  = 1'b1;
    logic lock_held = 1'b0; // Last acked master has not dropped cyc yet
    int   last_ack  = 0;
    int   fair_last = -1;

    wb_shared_bus u_wb_shared_bus (
        .clk    (clk),
        .rst    (rst),
        .m_cyc  (m_cyc),
        .m_stb  (m_stb),
        .m_we   (m_we),
        .m_adr  (m_adr),
        .m_dat_w(m_dat_w),
        .m_sel  (m_sel),
        .m_ack  (m_ack),
        .m_dat_r(m_dat_r)
    );

    always #5 clk = ~clk; // 10 ns period

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int m, input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state[m] = lfsr_step(lfsr_state[m]); // One step per bit
            r = {r[30:0], lfsr_state[m][0]};
        end
        return r;
    endfunction

    // One classic transfer that returns at the negedge after the gap cycle
    task automatic transfer(input int m, input logic we, input wb_addr_t adr,
                            input wb_data_t dat, input wb_sel_t sel,
                            input logic keep_cyc, output int cycles);
        cycles     = 0;
        m_cyc[m]   = 1'b1;
        m_stb[m]   = 1'b1;
        m_we[m]    = we;
        m_adr[m]   = adr;
        m_dat_w[m] = dat;
        m_sel[m]   = sel;
        do begin
            @(negedge clk);
            cycles++;
        end while (!m_ack[m]);
        m_stb[m] = 1'b0;
        if (!keep_cyc) begin
            m_cyc[m] = 1'b0; // Bus released on the next edge
        end
        @(negedge clk);
    endtask

    task automatic random_transfer(input int m, input logic keep_cyc);
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
        int       cycles;
        we  = 1'(take_bits(m, 1));
        adr = wb_addr_t'(take_bits(m, `WB_ADDR_W));
        dat = take_bits(m, `WB_DATA_W);
        sel = wb_sel_t'(take_bits(m, `WB_DATA_W / 8)); // Zero select is a legal no-op
        transfer(m, we, adr, dat, sel, keep_cyc, cycles);
    endtask

    // Whole RAM defined before any read with each byte carrying its address
    task automatic fill_ram(input int m);
        wb_addr_t a;
        int       cycles;
        for (int w = 0; w < WORDS; w++) begin
            a = wb_addr_t'(w);
            transfer(m, 1'b1, a, {2'b11, a, 2'b10, a, 2'b01, a, 2'b00, a}, '1, 1'b0, cycles);
        end
    endtask

    task automatic single_transfers(input int m, input int n, input int delay);
        repeat (delay) @(negedge clk);
        repeat (n) random_transfer(m, 1'b0);
    endtask

    // Holds cyc across n transfers and drops it after the last
    task automatic locked_series(input int m, input int n);
        for (int k = 0; k < n; k++) begin
            random_transfer(m, k != n - 1);
        end
    endtask

    task automatic mixed_traffic(input int m, input int n);
        logic keep;
        for (int k = 0; k < n; k++) begin
            keep = (k != n - 1) && (take_bits(m, 2) == 0); // About one in four locked
            random_transfer(m, keep);
            if (!keep) begin
                repeat (take_bits(m, 2)) @(negedge clk); // Random idle gap
            end
        end
    endtask

    // Sample 1 ns after the rising edge while outputs are settled and inputs steady
    always @(posedge clk) begin
        int acked;
        #1;
        acked = -1;
        if (rst || prev_rst) begin
            assert (m_ack == '0)
                else report_fail($sformatf("ERROR at %0t: m_ack = %b, expected 0 around reset",
                                           $time, m_ack));
        end
        prev_rst = rst;
        if (!fair_mode) begin
            fair_last = -1;
        end
        if (lock_held && !m_cyc[last_ack]) begin
            lock_held = 1'b0; // Owner let go
        end
        for (int i = 0; i < PORTS; i++) begin
            if (m_ack[i]) begin
                assert (m_cyc[i] && m_stb[i])
                    else report_fail($sformatf("ERROR at %0t: m_ack[%0d] high without cyc and stb",
                                               $time, i));
                acked = i;
            end
        end
        if (acked >= 0) begin
            if (lock_held) begin
                assert (acked == last_ack)
                    else report_fail($sformatf(
                        "ERROR at %0t: m_ack[%0d] while master %0d holds cyc",
                        $time, acked, last_ack));
            end
            if (fair_mode && fair_last >= 0) begin
                assert (acked == (fair_last + 1) % PORTS)
                    else report_fail($sformatf("ERROR at %0t: m_ack index = %0d, expected %0d",
                                               $time, acked, (fair_last + 1) % PORTS));
            end
            fair_last = acked;
            if (m_we[acked]) begin
                for (int b = 0; b < `WB_DATA_W / 8; b++) begin
                    if (m_sel[acked][b]) begin
                        ref_mem[m_adr[acked]][b*8 +: 8] = m_dat_w[acked][b*8 +: 8];
                    end
                end
            end else begin
                assert (m_dat_r[acked] == ref_mem[m_adr[acked]])
                    else report_fail($sformatf("ERROR at %0t: m_dat_r[%0d] = %h, expected %h",
                                               $time, acked, m_dat_r[acked],
                                               ref_mem[m_adr[acked]]));
            end
            last_ack  = acked;
            lock_held = 1'b1;
        end
    end

    // One master at most and never two acks in a row
    assert property (@(posedge clk) $onehot0(m_ack))
        else report_fail("ERROR: more than one master acknowledged in the same cycle");
    assert property (@(posedge clk) disable iff (rst) (|m_ack) |=> !(|m_ack))
        else report_fail("ERROR: acknowledge lasted longer than one cycle");

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fail($sformatf("ERROR at %0t: watchdog expired, transfers never finished", $time));
    end

    initial begin
        int cycles;
        rst       = 1'b1;
        m_cyc     = '1; // All masters request through reset
        m_stb     = '1;
        m_we      = '0;
        fair_mode = 1'b0;
        for (int m = 0; m < PORTS; m++) begin
            m_adr[m]      = '0;
            m_dat_w[m]    = '0;
            m_sel[m]      = '0;
            lfsr_state[m] = 32'h361b;
            void'(take_bits(m, m * 17)); // Spread the masters apart
        end
        repeat (10) @(negedge clk);
        rst   = 1'b0;
        m_cyc = '0; // Requests withdrawn as reset ends
        m_stb = '0;
        @(negedge clk);

        fill_ram(0);

        // Idle bus with each master alone
        for (int m = 0; m < PORTS; m++) begin
            transfer(m, 1'b0, wb_addr_t'(m * 9), '0, '1, 1'b0, cycles);
            assert (cycles == 2)
                else report_fail($sformatf("ERROR at %0t: m_ack[%0d] latency = %0d, expected 2",
                                           $time, m, cycles));
        end

        fair_mode = 1'b1;
        fork
            single_transfers(0, FAIR_XFERS, 0);
            single_transfers(1, FAIR_XFERS, 0);
            single_transfers(2, FAIR_XFERS, 0);
            single_transfers(3, FAIR_XFERS, 0);
        join
        fair_mode = 1'b0;

        // Master 2 owns the bus first while the rest queue behind it
        fork
            locked_series(2, LOCK_XFERS);
            single_transfers(0, 2, 2);
            single_transfers(1, 2, 2);
            single_transfers(3, 2, 2);
        join

        fork
            mixed_traffic(0, MIX_XFERS);
            mixed_traffic(1, MIX_XFERS);
            mixed_traffic(2, MIX_XFERS);
            mixed_traffic(3, MIX_XFERS);
        join

        repeat (2) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/wb_bus_pkg.sv
src/priority_encoder.sv
src/arbiter.sv
src/wb_master_mux.sv
src/wb_ram.sv
src/wb_shared_bus.sv
testbench/tb_wb_shared_bus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the shared bus and its testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module tb_wb_shared_bus -o sim_tb

# The run may stop on a fatal error, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Result: FAIL"
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    echo "Result: FAIL, run ended without a verdict"
    exit 1
fi
echo "Result: PASS"
